// File: tb.f
+incdir+.
rv_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core.sv
tb_rv_core.sv

// File: tb_rv_model.svh
// Reference model for the RV32I core testbench, included inside the testbench module
// Random source, ALU rules taken from the ISA, and the in-order expected-result queue

`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic [31:0] n;
	n = s >> 1;
	if (s[0])
		n = n ^ 32'h8020_0003;
	return n;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int k = 0; k < n; k++)
	begin
		lfsr_state = lfsr_next(lfsr_state);
		v = {v[30:0], lfsr_state[0]};
	end
	return v;
endfunction

// Integer ALU as the ISA defines it, alt is instruction bit 30
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic is_reg, input logic [31:0] a, input logic [31:0] b);
	case (f3)
		3'd0:    return (is_reg && alt) ? a - b : a + b;
		3'd1:    return a << b[4:0];
		3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'd3:    return (a < b) ? 32'd1 : 32'd0;
		3'd4:    return a ^ b;
		3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'd6:    return a | b;
		default: return a & b;
	endcase
endfunction

// Executes one accepted word on the shadow registers, queues its outcome
task automatic model_accept(input logic [31:0] w);
	logic [6:0]  f7;
	logic [2:0]  f3;
	logic [4:0]  rd;
	logic [31:0] res;
	logic        ok;
	exp_t        e;
	f7  = w[31:25];
	f3  = w[14:12];
	rd  = w[11:7];
	res = '0;
	ok  = 1'b1;
	case (w[6:0])
		rv_pkg::opc_op:
		begin
			// Bit 30 only for SUB and SRA
			ok  = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
			res = alu_ref(f3, w[30], 1'b1, shadow[w[19:15]], shadow[w[24:20]]);
		end
		rv_pkg::opc_op_imm:
		begin
			if (f3 == 3'd1)
				ok = (f7 == 7'h00);
			else if (f3 == 3'd5)
				ok = (f7 == 7'h00) || (f7 == 7'h20);
			res = alu_ref(f3, w[30], 1'b0, shadow[w[19:15]], {{20{w[31]}}, w[31:20]});
		end
		rv_pkg::opc_lui:
			res = {w[31:12], 12'h000};
		default:
			ok = 1'b0;
	endcase
	e.kind    = !ok;
	e.rd      = ok ? rd : 5'd0;
	e.data    = ok ? res : 32'd0;
	e.acc_cyc = cyc;
	e.halts   = halt_cnt;
	// Legal writes to x0 leave no trace
	if (!ok || (rd != 5'd0))
	begin
		if (ok)
			shadow[rd] = res;
		pending.push_back(e);
		exp_cnt++;
	end
endtask

`endif

// File: tb_rv_core.sv
// Testbench for the three-stage RV32I core
// Random ALU and LUI traffic with gaps and halt bursts, checked against a shadow model

`timescale 1ns/10ps

module tb_rv_core;

	localparam int num_insts      = 400;
	localparam int reset_cycles   = 16;
	// Worst case per instruction is 7 cycles with gaps and halts
	localparam int timeout_cycles = num_insts * 8 + 200;

	// Expected outcome of one accepted instruction
	typedef struct packed {
		logic        kind;
		logic [4:0]  rd;
		logic [31:0] data;
		logic [31:0] acc_cyc;
		logic [31:0] halts;
	} exp_t;

	logic        clk = 1'b0;
	logic        rst_n;
	logic [31:0] i_inst;
	logic        i_inst_valid;
	logic        i_halt;
	logic        o_wb_valid;
	logic [4:0]  o_wb_rd;
	logic [31:0] o_wb_data;
	logic        o_dec_err;

	// Model state
	logic [31:0] lfsr_state = 32'hd486;
	logic [31:0] shadow [0:31];
	exp_t        pending [$];
	exp_t        head;
	logic        head_valid = 1'b0;
	logic [31:0] cyc = '0;
	logic [31:0] halt_cnt = '0;
	int          exp_cnt = 0;
	int          pop_cnt = 0;

	`include "tb_rv_model.svh"

	rv_core u_rv_core (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_inst       (i_inst),
		.i_inst_valid (i_inst_valid),
		.i_halt       (i_halt),
		.o_wb_valid   (o_wb_valid),
		.o_wb_rd      (o_wb_rd),
		.o_wb_data    (o_wb_data),
		.o_dec_err    (o_dec_err)
	);

	always #20 clk = ~clk;

	// ==================================================
	// Stimulus generation
	// ==================================================
	// Mostly x1..x4 for frequent hazards, x0 now and then
	function automatic logic [4:0] pick_reg();
		logic [4:0] r;
		r = (rand_bits(3) == 0) ? 5'd0 : 5'd1 + 5'(rand_bits(2));
		return r;
	endfunction

	function automatic logic [31:0] gen_inst();
		logic [2:0]  cls;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
		logic [19:0] upper;
		logic [31:0] w;
		cls = 3'(rand_bits(3));
		f3  = 3'(rand_bits(3));
		rd  = pick_reg();
		rs1 = pick_reg();
		rs2 = pick_reg();
		imm = 12'(rand_bits(12));
		if (cls <= 3'd2)
		begin
			// SUB or SRA half the time where allowed
			w = {7'h00, rs2, rs1, f3, rd, rv_pkg::opc_op};
			if (((f3 == 3'd0) || (f3 == 3'd5)) && rand_bits(1))
				w[30] = 1'b1;
		end
		else if (cls <= 3'd5)
		begin
			if (f3 == 3'd1)
				imm[11:5] = 7'h00;
			else if (f3 == 3'd5)
				imm[11:5] = rand_bits(1) ? 7'h20 : 7'h00;
			w = {imm, rs1, f3, rd, rv_pkg::opc_op_imm};
		end
		else if (cls == 3'd6)
		begin
			upper = 20'(rand_bits(20));
			w = {upper, rd, rv_pkg::opc_lui};
		end
		else
		begin
			// Load, store, branch or JAL, none supported
			w = rand_bits(32);
			case (rand_bits(2))
				0:       w[6:0] = 7'b0000011;
				1:       w[6:0] = 7'b0100011;
				2:       w[6:0] = 7'b1100011;
				default: w[6:0] = 7'b1101111;
			endcase
		end
		return w;
	endfunction

	initial
	begin
		rst_n        = 1'b0;
		i_inst       = '0;
		i_inst_valid = 1'b0;
		i_halt       = 1'b0;
		for (int k = 0; k < 32; k++)
			shadow[k] = '0;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;

		for (int n = 0; n < num_insts; n++)
		begin
			@(posedge clk);
			i_inst       <= gen_inst();
			i_inst_valid <= 1'b1;
			i_halt       <= 1'b0;
			// Idle gap of one or two cycles
			if (rand_bits(2) == 0)
			begin
				repeat (1 + rand_bits(1))
				begin
					@(posedge clk);
					i_inst_valid <= 1'b0;
					i_inst       <= '0;
				end
			end
			// Halt burst, input words offered meanwhile must be dropped
			if (rand_bits(3) == 0)
			begin
				repeat (1 + rand_bits(2))
				begin
					@(posedge clk);
					i_halt       <= 1'b1;
					i_inst_valid <= 1'(rand_bits(1));
					i_inst       <= rand_bits(32);
				end
			end
		end
		@(posedge clk);
		i_inst_valid <= 1'b0;
		i_halt       <= 1'b0;

		// Drain, then a few idle cycles to catch stray strobes
		while (pending.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);
		if (pop_cnt == exp_cnt)
		begin
			$display("TEST PASSED");
			$finish;
		end
		else
		begin
			$display("Saw %0d result strobes, expected %0d", pop_cnt, exp_cnt);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	// ==================================================
	// Model bookkeeping
	// ==================================================
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			if (o_wb_valid || o_dec_err)
			begin
				if (pending.size() != 0)
					void'(pending.pop_front());
				pop_cnt++;
			end
			if (i_inst_valid && !i_halt)
				model_accept(i_inst);
			if (i_halt)
				halt_cnt <= halt_cnt + 1;
		end
		cyc        <= cyc + 1;
		head_valid <= (pending.size() != 0);
		if (pending.size() != 0)
			head <= pending[0];
	end

	always @(posedge clk)
	begin
		if (cyc >= timeout_cycles)
		begin
			$display("Timeout after %0d cycles with %0d results outstanding",
				cyc, pending.size());
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	// ==================================================
	// Checks
	// ==================================================
	a_strobe_expected: assert property (@(posedge clk) disable iff (!rst_n)
		(o_wb_valid || o_dec_err) |-> head_valid)
	else
	begin
		$display("Result strobe at %0t with no instruction outstanding", $time);
		$display("TEST FAILED");
		$fatal(1);
	end

	a_kind_wb: assert property (@(posedge clk) disable iff (!rst_n)
		(o_wb_valid && head_valid) |-> !head.kind)
	else
	begin
		$display("o_wb_valid at %0t where a decode error was due", $time);
		$display("TEST FAILED");
		$fatal(1);
	end

	a_kind_err: assert property (@(posedge clk) disable iff (!rst_n)
		(o_dec_err && head_valid) |-> head.kind)
	else
	begin
		$display("o_dec_err at %0t where a write-back was due", $time);
		$display("TEST FAILED");
		$fatal(1);
	end

	a_wb_rd: assert property (@(posedge clk) disable iff (!rst_n)
		(o_wb_valid && head_valid && !head.kind) |-> (o_wb_rd == head.rd))
	else
	begin
		$display("MISMATCH time=%0t o_wb_rd got=%0d exp=%0d", $time,
			$sampled(o_wb_rd), $sampled(head.rd));
		$display("TEST FAILED");
		$fatal(1);
	end

	a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
		(o_wb_valid && head_valid && !head.kind) |-> (o_wb_data == head.data))
	else
	begin
		$display("MISMATCH time=%0t o_wb_data got=%h exp=%h", $time,
			$sampled(o_wb_data), $sampled(head.data));
		$display("TEST FAILED");
		$fatal(1);
	end

	// Two edges through the pipe plus one per halted edge
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		((o_wb_valid || o_dec_err) && head_valid) |->
		((cyc - head.acc_cyc) == (32'd3 + halt_cnt - head.halts)))
	else
	begin
		$display("MISMATCH time=%0t result latency got=%0d exp=%0d", $time,
			$sampled(cyc - head.acc_cyc), $sampled(32'd3 + halt_cnt - head.halts));
		$display("TEST FAILED");
		$fatal(1);
	end

endmodule

// File: rv_core.sv
// Top of the three-stage RV32I integer core
// One word per cycle on i_inst_valid, results two edges later unless halted

`timescale 1ns/10ps

module rv_core (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [rv_pkg::xlen-1:0]       i_inst,
	input  logic                          i_inst_valid,
	input  logic                          i_halt,
	output logic                          o_wb_valid,
	output logic [rv_pkg::reg_addr_w-1:0] o_wb_rd,
	output logic [rv_pkg::xlen-1:0]       o_wb_data,
	output logic                          o_dec_err
);

	// Register file read ports
	logic [rv_pkg::reg_addr_w-1:0] rs1;
	logic [rv_pkg::reg_addr_w-1:0] rs2;
	logic [rv_pkg::xlen-1:0]       rs1_data;
	logic [rv_pkg::xlen-1:0]       rs2_data;

	// Stage links
	rv_pkg::dec_ex_t dec_ex;
	rv_pkg::ex_wb_t  ex_wb;
	rv_pkg::wb_t     wb;

	// ==================================================
	// Stages
	// ==================================================
	rv_decode u_decode (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_inst       (i_inst),
		.i_inst_valid (i_inst_valid),
		.i_halt       (i_halt),
		.o_rs1        (rs1),
		.o_rs2        (rs2),
		.i_rs1_data   (rs1_data),
		.i_rs2_data   (rs2_data),
		.o_dec_ex     (dec_ex)
	);

	rv_execute u_execute (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_halt   (i_halt),
		.i_dec_ex (dec_ex),
		.i_fwd    (wb),
		.o_ex_wb  (ex_wb)
	);

	rv_result u_result (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_halt     (i_halt),
		.i_ex_wb    (ex_wb),
		.o_wb       (wb),
		.o_wb_valid (o_wb_valid),
		.o_wb_rd    (o_wb_rd),
		.o_wb_data  (o_wb_data),
		.o_dec_err  (o_dec_err)
	);

	// Written from the result stage, read by decode
	rv_regfile u_regfile (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_rs1      (rs1),
		.i_rs2      (rs2),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data),
		.i_wb       (wb)
	);

endmodule

// File: rv_result.sv
// Result stage: write-back register for the register file, forwarding and outputs
// Legal items with rd non-zero strobe o_wb_valid, illegal ones o_dec_err

`timescale 1ns/10ps

module rv_result (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          i_halt,
	input  rv_pkg::ex_wb_t                i_ex_wb,
	output rv_pkg::wb_t                   o_wb,
	output logic                          o_wb_valid,
	output logic [rv_pkg::reg_addr_w-1:0] o_wb_rd,
	output logic [rv_pkg::xlen-1:0]       o_wb_data,
	output logic                          o_dec_err
);

	rv_pkg::ex_wb_t res_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			res_q <= '0;
		else if (i_halt)
		begin
			// Bubble while upstream is frozen
			res_q.valid   <= 1'b0;
			res_q.illegal <= 1'b0;
		end
		else
		begin
			res_q.valid   <= i_ex_wb.valid && !i_ex_wb.illegal && (i_ex_wb.rd != '0);
			res_q.illegal <= i_ex_wb.valid && i_ex_wb.illegal;
			res_q.rd      <= i_ex_wb.rd;
			res_q.result  <= i_ex_wb.result;
		end
	end

	// Register file write and forwarding source
	assign o_wb.valid = res_q.valid;
	assign o_wb.rd    = res_q.rd;
	assign o_wb.data  = res_q.result;

	assign o_wb_valid = res_q.valid;
	assign o_wb_rd    = res_q.rd;
	assign o_wb_data  = res_q.result;
	assign o_dec_err  = res_q.illegal;

	a_one_outcome: assert property (@(posedge clk) disable iff (!rst_n)
		!(o_wb_valid && o_dec_err));

endmodule

// File: rv_execute.sv
// Execute stage: holds the decoded item, selects forwarded operands, runs the ALU
// Forwarding comes from the write-back register one stage ahead

`timescale 1ns/10ps

module rv_execute (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            i_halt,
	input  rv_pkg::dec_ex_t i_dec_ex,
	input  rv_pkg::wb_t     i_fwd,
	output rv_pkg::ex_wb_t  o_ex_wb
);

	rv_pkg::dec_ex_t         ex_q;
	logic                    fwd_a;
	logic                    fwd_b;
	logic [rv_pkg::xlen-1:0] op_a;
	logic [rv_pkg::xlen-1:0] op_b;
	logic [4:0]              shamt;
	logic [rv_pkg::xlen-1:0] result;

	// ==================================================
	// Execute register
	// ==================================================
	// Write-back matches a source of the held item
	assign fwd_a = i_fwd.valid && (i_fwd.rd == ex_q.rs1);
	assign fwd_b = i_fwd.valid && (i_fwd.rd == ex_q.rs2);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ex_q <= '0;
		else if (i_halt)
		begin
			// Held item keeps the value retiring under it,
			// the result stage goes empty and can no longer forward it
			if (fwd_a)
				ex_q.rs1_data <= i_fwd.data;
			if (fwd_b)
				ex_q.rs2_data <= i_fwd.data;
		end
		else
			ex_q <= i_dec_ex;
	end

	// ==================================================
	// Operand select
	// ==================================================
	always_comb
	begin
		if (ex_q.use_zero_a)
			op_a = '0;
		else if (fwd_a)
			op_a = i_fwd.data;
		else
			op_a = ex_q.rs1_data;

		if (ex_q.use_imm)
			op_b = ex_q.imm;
		else if (fwd_b)
			op_b = i_fwd.data;
		else
			op_b = ex_q.rs2_data;
	end

	// ==================================================
	// ALU
	// ==================================================
	// Shift amount from low 5 bits
	assign shamt = op_b[4:0];

	always_comb
	begin
		case (ex_q.alu_op)
			rv_pkg::alu_add:    result = op_a + op_b;
			rv_pkg::alu_sub:    result = op_a - op_b;
			rv_pkg::alu_sll:    result = op_a << shamt;
			rv_pkg::alu_slt:    result = {31'b0, $signed(op_a) < $signed(op_b)};
			rv_pkg::alu_sltu:   result = {31'b0, op_a < op_b};
			rv_pkg::alu_xor:    result = op_a ^ op_b;
			rv_pkg::alu_srl:    result = op_a >> shamt;
			rv_pkg::alu_sra:    result = $unsigned($signed(op_a) >>> shamt);
			rv_pkg::alu_or:     result = op_a | op_b;
			rv_pkg::alu_and:    result = op_a & op_b;
			rv_pkg::alu_pass_b: result = op_b;
			default:            result = '0;
		endcase
	end

	// Item towards the result stage
	assign o_ex_wb.valid   = ex_q.valid;
	assign o_ex_wb.illegal = ex_q.illegal;
	assign o_ex_wb.rd      = ex_q.rd;
	assign o_ex_wb.result  = result;

endmodule

// File: rv_decode.sv
// Decode stage: holds the accepted instruction word and decodes it
// Reads the register file and builds the decode-to-execute item

`timescale 1ns/10ps

module rv_decode (
	input  logic                          clk,
	input  logic                          rst_n,
	input  rv_pkg::inst_u                 i_inst,
	input  logic                          i_inst_valid,
	input  logic                          i_halt,
	output logic [rv_pkg::reg_addr_w-1:0] o_rs1,
	output logic [rv_pkg::reg_addr_w-1:0] o_rs2,
	input  logic [rv_pkg::xlen-1:0]       i_rs1_data,
	input  logic [rv_pkg::xlen-1:0]       i_rs2_data,
	output rv_pkg::dec_ex_t               o_dec_ex
);

	rv_pkg::inst_u inst_q;
	logic          valid_q;
	// Upper seven bits, funct7 or top of the shift immediate
	logic [6:0]    f7;
	logic          f7_alt;
	logic          f7_base;

	// Maps funct3 to the ALU operation
	function automatic rv_pkg::alu_op_e alu_from_f3(input logic [2:0] f3,
			input logic alt_sub, input logic alt_sra);
		case (f3)
			rv_pkg::f3_add_sub: alu_from_f3 = alt_sub ? rv_pkg::alu_sub : rv_pkg::alu_add;
			rv_pkg::f3_sll:     alu_from_f3 = rv_pkg::alu_sll;
			rv_pkg::f3_slt:     alu_from_f3 = rv_pkg::alu_slt;
			rv_pkg::f3_sltu:    alu_from_f3 = rv_pkg::alu_sltu;
			rv_pkg::f3_xor:     alu_from_f3 = rv_pkg::alu_xor;
			rv_pkg::f3_srl_sra: alu_from_f3 = alt_sra ? rv_pkg::alu_sra : rv_pkg::alu_srl;
			rv_pkg::f3_or:      alu_from_f3 = rv_pkg::alu_or;
			rv_pkg::f3_and:     alu_from_f3 = rv_pkg::alu_and;
			default:            alu_from_f3 = rv_pkg::alu_add;
		endcase
	endfunction

	// ==================================================
	// Decode register
	// ==================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			valid_q <= 1'b0;
		else if (!i_halt)
			valid_q <= i_inst_valid;
	end

	// Word only loads on acceptance
	always_ff @(posedge clk)
	begin
		if (i_inst_valid && !i_halt)
			inst_q <= i_inst;
	end

	// ==================================================
	// Decoder
	// ==================================================
	assign o_rs1 = inst_q.r.rs1;
	assign o_rs2 = inst_q.r.rs2;

	// Same bits as imm12[11:5] of OP-IMM shifts
	assign f7      = inst_q.r.funct7;
	assign f7_alt  = (f7 == rv_pkg::f7_alt);
	assign f7_base = (f7 == rv_pkg::f7_base);

	always_comb
	begin
		o_dec_ex            = '0;
		o_dec_ex.valid      = valid_q;
		o_dec_ex.alu_op     = rv_pkg::alu_add;
		o_dec_ex.rs1        = inst_q.r.rs1;
		o_dec_ex.rs2        = inst_q.r.rs2;
		o_dec_ex.rd         = inst_q.r.rd;
		o_dec_ex.rs1_data   = i_rs1_data;
		o_dec_ex.rs2_data   = i_rs2_data;
		// Sign-extended I immediate by default
		o_dec_ex.imm        = {{20{inst_q.i.imm12[11]}}, inst_q.i.imm12};

		case (inst_q.r.opcode)
			rv_pkg::opc_op:
			begin
				o_dec_ex.alu_op  = alu_from_f3(inst_q.r.funct3, f7_alt, f7_alt);
				// Alternate funct7 only for SUB and SRA
				o_dec_ex.illegal = !(f7_base || (f7_alt &&
					((inst_q.r.funct3 == rv_pkg::f3_add_sub) ||
					 (inst_q.r.funct3 == rv_pkg::f3_srl_sra))));
			end
			rv_pkg::opc_op_imm:
			begin
				o_dec_ex.use_imm = 1'b1;
				o_dec_ex.alu_op  = alu_from_f3(inst_q.i.funct3, 1'b0, f7_alt);
				// Shift amount field must be clean
				if (inst_q.i.funct3 == rv_pkg::f3_sll)
					o_dec_ex.illegal = !f7_base;
				else if (inst_q.i.funct3 == rv_pkg::f3_srl_sra)
					o_dec_ex.illegal = !(f7_base || f7_alt);
			end
			rv_pkg::opc_lui:
			begin
				o_dec_ex.alu_op     = rv_pkg::alu_pass_b;
				o_dec_ex.use_imm    = 1'b1;
				o_dec_ex.use_zero_a = 1'b1;
				// Upper 20 bits of the word, low 12 cleared
				o_dec_ex.imm = {inst_q.i.imm12, inst_q.i.rs1, inst_q.i.funct3, 12'b0};
			end
			default:
				o_dec_ex.illegal = 1'b1;
		endcase

		// No write-back for unsupported encodings
		if (o_dec_ex.illegal)
			o_dec_ex.rd = '0;
	end

	a_alu_op_known: assert property (@(posedge clk) disable iff (!rst_n)
		(o_dec_ex.valid && !o_dec_ex.illegal) |->
		(o_dec_ex.alu_op inside {rv_pkg::alu_add, rv_pkg::alu_sub, rv_pkg::alu_sll,
			rv_pkg::alu_slt, rv_pkg::alu_sltu, rv_pkg::alu_xor, rv_pkg::alu_srl,
			rv_pkg::alu_sra, rv_pkg::alu_or, rv_pkg::alu_and, rv_pkg::alu_pass_b}));

endmodule

// File: rv_regfile.sv
// 32-entry integer register file with two read ports and one write port
// A write in flight is seen by the reads of the same cycle

`timescale 1ns/10ps

module rv_regfile (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [rv_pkg::reg_addr_w-1:0] i_rs1,
	input  logic [rv_pkg::reg_addr_w-1:0] i_rs2,
	output logic [rv_pkg::xlen-1:0]       o_rs1_data,
	output logic [rv_pkg::xlen-1:0]       o_rs2_data,
	input  rv_pkg::wb_t                   i_wb
);

	// x1..x31 only, x0 is not stored
	logic [rv_pkg::xlen-1:0] regs [1:rv_pkg::num_regs-1];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int k = 1; k < rv_pkg::num_regs; k++)
				regs[k] <= '0;
		end
		else if (i_wb.valid && (i_wb.rd != '0))
			regs[i_wb.rd] <= i_wb.data;
	end

	// Read with write-through, x0 always zero
	always_comb
	begin
		if (i_rs1 == '0)
			o_rs1_data = '0;
		else if (i_wb.valid && (i_wb.rd == i_rs1))
			o_rs1_data = i_wb.data;
		else
			o_rs1_data = regs[i_rs1];

		if (i_rs2 == '0)
			o_rs2_data = '0;
		else if (i_wb.valid && (i_wb.rd == i_rs2))
			o_rs2_data = i_wb.data;
		else
			o_rs2_data = regs[i_rs2];
	end

	// Result stage filters rd 0 before it reaches this port
	a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
		i_wb.valid |-> (i_wb.rd != '0));

endmodule

// File: rv_pkg.sv
// Shared widths, opcode constants and stage structs for the three-stage RV32I core
// Every design file refers to these by scoped name, nothing is imported

package rv_pkg;

	// ==================================================
	// Widths
	// ==================================================
	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;
	localparam int num_regs   = 32;

	// ==================================================
	// Opcodes and function fields
	// ==================================================
	// Register-register ALU group
	localparam logic [6:0] opc_op     = 7'b0110011;
	// Register-immediate ALU group
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	// Load upper immediate
	localparam logic [6:0] opc_lui    = 7'b0110111;

	// funct3 encodings shared by OP and OP-IMM
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_srl_sra = 3'b101;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	// funct7, also the top of the shift immediate
	localparam logic [6:0] f7_base = 7'b0000000;
	// Selects SUB or SRA
	localparam logic [6:0] f7_alt  = 7'b0100000;

	// ALU operation, 4 bits
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b
	} alu_op_e;

	// ==================================================
	// Instruction views
	// ==================================================
	typedef struct packed {
		logic [6:0]            funct7;
		logic [reg_addr_w-1:0] rs2;
		logic [reg_addr_w-1:0] rs1;
		logic [2:0]            funct3;
		logic [reg_addr_w-1:0] rd;
		logic [6:0]            opcode;
	} inst_r_t;

	typedef struct packed {
		logic [11:0]           imm12;
		logic [reg_addr_w-1:0] rs1;
		logic [2:0]            funct3;
		logic [reg_addr_w-1:0] rd;
		logic [6:0]            opcode;
	} inst_i_t;

	// Same 32-bit word, read as R-type or I-type
	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_u;

	// ==================================================
	// Stage structs
	// ==================================================
	// Decode to execute, 119 bits
	typedef struct packed {
		logic                  valid;
		logic                  illegal;
		alu_op_e               alu_op;
		logic                  use_imm;
		// LUI takes zero as operand A
		logic                  use_zero_a;
		logic [reg_addr_w-1:0] rs1;
		logic [reg_addr_w-1:0] rs2;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       rs1_data;
		logic [xlen-1:0]       rs2_data;
		logic [xlen-1:0]       imm;
	} dec_ex_t;

	// Execute to result, 39 bits
	typedef struct packed {
		logic                  valid;
		logic                  illegal;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       result;
	} ex_wb_t;

	// Register file write and forwarding source, 38 bits
	typedef struct packed {
		logic                  valid;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       data;
	} wb_t;

endpackage
